/* logic/traffic_pkg.sv */
package traffic_pkg;

	// phase timer width, big enough for the longest interval
	localparam int timer_w = 6;

	typedef logic [timer_w-1:0] timer_t;

	// one value per signal phase of the intersection
	typedef enum logic [3:0] {
		ph_ew_green,
		ph_ew_walk,
		ph_ew_flash,
		ph_ew_clear,
		ph_ew_amber,
		ph_red_a,
		ph_sb_left,
		ph_ns_green,
		ph_ns_walk,
		ph_ns_flash,
		ph_ns_clear,
		ph_ns_amber,
		ph_red_b
	} phase_t;

	// interval lengths in clock cycles
	localparam timer_t green_time   = timer_t'(60);
	localparam timer_t walk_time    = timer_t'(10);
	localparam timer_t flash_time   = timer_t'(20);
	localparam timer_t clear_time   = timer_t'(30);
	localparam timer_t amber_time   = timer_t'(6);
	localparam timer_t all_red_time = timer_t'(2);
	localparam timer_t left_time    = timer_t'(20);

	// controller wakes up in east-west green
	localparam phase_t reset_phase = ph_ew_green;

	// walk + flash + clear adds up to one plain green
	function automatic timer_t phase_duration(input phase_t p);
		timer_t d;
		case (p)
			ph_ew_green, ph_ns_green: d = green_time;
			ph_ew_walk, ph_ns_walk:   d = walk_time;
			ph_ew_flash, ph_ns_flash: d = flash_time;
			ph_ew_clear, ph_ns_clear: d = clear_time;
			ph_ew_amber, ph_ns_amber: d = amber_time;
			ph_red_a, ph_red_b:       d = all_red_time;
			ph_sb_left:               d = left_time;
			// unreachable codes get the shortest safe interval
			default:                  d = all_red_time;
		endcase
		return d;
	endfunction

endpackage

/* logic/request_latch.sv */
module request_latch (
	input  logic clk,
	input  logic reset,
	input  logic walk_request,
	input  logic southbound_left_request,
	input  logic walk_served,
	input  logic left_served,
	output logic walk_waiting,
	output logic left_waiting
);

	// pedestrian push button, sticky until a walk phase is entered
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			walk_waiting <= 1'b0;
		end else if (walk_served) begin
			// serving wins over a press in the same cycle
			walk_waiting <= 1'b0;
		end else if (walk_request) begin
			walk_waiting <= 1'b1;
		end
	end

	// southbound left detector, sticky until the left phase is entered
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			left_waiting <= 1'b0;
		end else if (left_served) begin
			left_waiting <= 1'b0;
		end else if (southbound_left_request) begin
			left_waiting <= 1'b1;
		end
	end

	// sequencer only branches into a serving phase on a pending request
	a_walk_served_pending: assert property (
		@(posedge clk) disable iff (reset) walk_served |-> walk_waiting
	);

	a_left_served_pending: assert property (
		@(posedge clk) disable iff (reset) left_served |-> left_waiting
	);

endmodule

/* logic/phase_timer.sv */
module phase_timer (
	input  logic                clk,
	input  logic                reset,
	input  logic                phase_load,
	input  traffic_pkg::phase_t next_phase,
	output logic                expired
);
	import traffic_pkg::*;

	timer_t count;

	// count runs duration..1, so a phase lasts exactly its duration
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// reset phase is timed like any other
			count <= phase_duration(reset_phase);
		end else if (phase_load) begin
			count <= phase_duration(next_phase);
		end else if (count != timer_t'(1)) begin
			count <= count - timer_t'(1);
		end
		// parked at 1 while the sequencer holds the phase
	end

	// last cycle of the phase, or any cycle of an emergency hold
	assign expired = (count == timer_t'(1));

	// a zero count would mean a missed expiry and a stuck phase
	a_count_nonzero: assert property (
		@(posedge clk) disable iff (reset) count != '0
	);

endmodule

/* logic/phase_sequencer.sv */
module phase_sequencer (
	input  logic                clk,
	input  logic                reset,
	input  logic                expired,
	input  logic                walk_waiting,
	input  logic                left_waiting,
	input  logic                evm_request,
	output traffic_pkg::phase_t phase,
	output traffic_pkg::phase_t next_phase,
	output logic                phase_load,
	output logic                walk_served,
	output logic                left_served
);
	import traffic_pkg::*;

	logic evm_hold;

	// successor of the current phase, only taken on phase_load
	always_comb begin
		case (phase)
			// east-west through movement
			ph_ew_green: next_phase = ph_ew_amber;
			ph_ew_walk:  next_phase = ph_ew_flash;
			ph_ew_flash: next_phase = ph_ew_clear;
			ph_ew_clear: next_phase = ph_ew_amber;
			ph_ew_amber: next_phase = ph_red_a;
			// all red, then left turn has priority over the walk
			ph_red_a: begin
				if (left_waiting) begin
					next_phase = ph_sb_left;
				end else if (walk_waiting) begin
					next_phase = ph_ns_walk;
				end else begin
					next_phase = ph_ns_green;
				end
			end
			ph_sb_left: begin
				if (walk_waiting) begin
					next_phase = ph_ns_walk;
				end else begin
					next_phase = ph_ns_green;
				end
			end
			// north-south through movement
			ph_ns_green: next_phase = ph_ns_amber;
			ph_ns_walk:  next_phase = ph_ns_flash;
			ph_ns_flash: next_phase = ph_ns_clear;
			ph_ns_clear: next_phase = ph_ns_amber;
			ph_ns_amber: next_phase = ph_red_b;
			// back to east-west, with walk if a pedestrian is waiting
			ph_red_b: begin
				if (walk_waiting) begin
					next_phase = ph_ew_walk;
				end else begin
					next_phase = ph_ew_green;
				end
			end
			default: next_phase = reset_phase;
		endcase
	end

	// emergency vehicle keeps east-west moving in green or clear
	assign evm_hold = evm_request && (phase == ph_ew_green || phase == ph_ew_clear);

	// leave the phase on expiry unless held
	assign phase_load = expired && !evm_hold;

	// served pulses line up with the edge that enters the serving phase
	assign walk_served = phase_load &&
		(next_phase == ph_ew_walk || next_phase == ph_ns_walk);
	assign left_served = phase_load && (next_phase == ph_sb_left);

	// single phase register instead of one-hot flops
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= reset_phase;
		end else if (phase_load) begin
			phase <= next_phase;
		end
	end

	// a phase never ends before the timer says so
	a_load_on_expiry: assert property (
		@(posedge clk) disable iff (reset) phase_load |-> expired
	);

	// held green stays green for the next cycle too
	a_evm_holds_green: assert property (
		@(posedge clk) disable iff (reset)
		(phase == ph_ew_green && evm_request) |=> phase == ph_ew_green
	);

	// same for the clear interval after an east-west walk
	a_evm_holds_clear: assert property (
		@(posedge clk) disable iff (reset)
		(phase == ph_ew_clear && evm_request) |=> phase == ph_ew_clear
	);

endmodule

/* logic/signal_heads.sv */
module signal_heads (
	input  traffic_pkg::phase_t phase,
	output logic northbound_green,
	output logic northbound_amber,
	output logic northbound_red,
	output logic northbound_walk,
	output logic northbound_flashing_dont_walk,
	output logic northbound_dont_walk,
	output logic southbound_green,
	output logic southbound_amber,
	output logic southbound_red,
	output logic southbound_left,
	output logic southbound_walk,
	output logic southbound_flashing_dont_walk,
	output logic southbound_dont_walk,
	output logic eastbound_green,
	output logic eastbound_amber,
	output logic eastbound_red,
	output logic eastbound_walk,
	output logic eastbound_flashing_dont_walk,
	output logic eastbound_dont_walk,
	output logic westbound_green,
	output logic westbound_amber,
	output logic westbound_red,
	output logic westbound_walk,
	output logic westbound_flashing_dont_walk,
	output logic westbound_dont_walk
);
	import traffic_pkg::*;

	logic ew_grn, ew_amb, ew_walk, ew_flash;
	logic ns_grn, ns_amb, ns_walk, ns_flash;
	logic sb_lft;

	// which phases light each lamp group
	always_comb begin
		ew_grn   = (phase == ph_ew_green) || (phase == ph_ew_walk) ||
			(phase == ph_ew_flash) || (phase == ph_ew_clear);
		ew_amb   = (phase == ph_ew_amber);
		ew_walk  = (phase == ph_ew_walk);
		ew_flash = (phase == ph_ew_flash);
		ns_grn   = (phase == ph_ns_green) || (phase == ph_ns_walk) ||
			(phase == ph_ns_flash) || (phase == ph_ns_clear);
		ns_amb   = (phase == ph_ns_amber);
		ns_walk  = (phase == ph_ns_walk);
		ns_flash = (phase == ph_ns_flash);
		sb_lft   = (phase == ph_sb_left);
	end

	// east and west heads always show the same aspect
	assign eastbound_green = ew_grn;
	assign eastbound_amber = ew_amb;
	assign eastbound_red   = !(ew_grn || ew_amb);
	assign westbound_green = ew_grn;
	assign westbound_amber = ew_amb;
	assign westbound_red   = !(ew_grn || ew_amb);

	// northbound stays red through the protected left
	assign northbound_green = ns_grn;
	assign northbound_amber = ns_amb;
	assign northbound_red   = !(ns_grn || ns_amb);

	// southbound shows the left arrow instead of red
	assign southbound_green = ns_grn;
	assign southbound_amber = ns_amb;
	assign southbound_red   = !(ns_grn || ns_amb || sb_lft);
	assign southbound_left  = sb_lft;

	// pedestrians crossing alongside east-west traffic
	assign eastbound_walk                = ew_walk;
	assign eastbound_flashing_dont_walk  = ew_flash;
	assign eastbound_dont_walk           = !(ew_walk || ew_flash);
	assign westbound_walk                = ew_walk;
	assign westbound_flashing_dont_walk  = ew_flash;
	assign westbound_dont_walk           = !(ew_walk || ew_flash);

	// pedestrians crossing alongside north-south traffic
	assign northbound_walk               = ns_walk;
	assign northbound_flashing_dont_walk = ns_flash;
	assign northbound_dont_walk          = !(ns_walk || ns_flash);
	assign southbound_walk               = ns_walk;
	assign southbound_flashing_dont_walk = ns_flash;
	assign southbound_dont_walk          = !(ns_walk || ns_flash);

	// conflicting greens must never show together
	always_comb begin
		a_no_conflict: assert final (
			!((eastbound_green || westbound_green) &&
			(northbound_green || southbound_green || southbound_left))
		);
	end

endmodule

/* logic/traffic_controller.sv */
module traffic_controller (
	input  logic clk,
	input  logic reset,
	input  logic walk_request,
	input  logic southbound_left_request,
	input  logic evm_request,
	output logic northbound_green,
	output logic northbound_amber,
	output logic northbound_red,
	output logic northbound_walk,
	output logic northbound_flashing_dont_walk,
	output logic northbound_dont_walk,
	output logic southbound_green,
	output logic southbound_amber,
	output logic southbound_red,
	output logic southbound_left,
	output logic southbound_walk,
	output logic southbound_flashing_dont_walk,
	output logic southbound_dont_walk,
	output logic eastbound_green,
	output logic eastbound_amber,
	output logic eastbound_red,
	output logic eastbound_walk,
	output logic eastbound_flashing_dont_walk,
	output logic eastbound_dont_walk,
	output logic westbound_green,
	output logic westbound_amber,
	output logic westbound_red,
	output logic westbound_walk,
	output logic westbound_flashing_dont_walk,
	output logic westbound_dont_walk
);
	import traffic_pkg::*;

	// request handshake between latch and sequencer
	logic walk_waiting, left_waiting;
	logic walk_served, left_served;
	// sequencer and timer loop
	phase_t phase, next_phase;
	logic phase_load, expired;

	request_latch u_request_latch (
		.clk                     (clk),
		.reset                   (reset),
		.walk_request            (walk_request),
		.southbound_left_request (southbound_left_request),
		.walk_served             (walk_served),
		.left_served             (left_served),
		.walk_waiting            (walk_waiting),
		.left_waiting            (left_waiting)
	);

	phase_timer u_phase_timer (
		.clk        (clk),
		.reset      (reset),
		.phase_load (phase_load),
		.next_phase (next_phase),
		.expired    (expired)
	);

	phase_sequencer u_phase_sequencer (
		.clk          (clk),
		.reset        (reset),
		.expired      (expired),
		.walk_waiting (walk_waiting),
		.left_waiting (left_waiting),
		.evm_request  (evm_request),
		.phase        (phase),
		.next_phase   (next_phase),
		.phase_load   (phase_load),
		.walk_served  (walk_served),
		.left_served  (left_served)
	);

	// lamps decode straight from the phase register
	signal_heads u_signal_heads (
		.phase                         (phase),
		.northbound_green              (northbound_green),
		.northbound_amber              (northbound_amber),
		.northbound_red                (northbound_red),
		.northbound_walk               (northbound_walk),
		.northbound_flashing_dont_walk (northbound_flashing_dont_walk),
		.northbound_dont_walk          (northbound_dont_walk),
		.southbound_green              (southbound_green),
		.southbound_amber              (southbound_amber),
		.southbound_red                (southbound_red),
		.southbound_left               (southbound_left),
		.southbound_walk               (southbound_walk),
		.southbound_flashing_dont_walk (southbound_flashing_dont_walk),
		.southbound_dont_walk          (southbound_dont_walk),
		.eastbound_green               (eastbound_green),
		.eastbound_amber               (eastbound_amber),
		.eastbound_red                 (eastbound_red),
		.eastbound_walk                (eastbound_walk),
		.eastbound_flashing_dont_walk  (eastbound_flashing_dont_walk),
		.eastbound_dont_walk           (eastbound_dont_walk),
		.westbound_green               (westbound_green),
		.westbound_amber               (westbound_amber),
		.westbound_red                 (westbound_red),
		.westbound_walk                (westbound_walk),
		.westbound_flashing_dont_walk  (westbound_flashing_dont_walk),
		.westbound_dont_walk           (westbound_dont_walk)
	);

endmodule

/* bench/traffic_controller_tb.sv */
module traffic_controller_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import traffic_pkg::*;

	typedef logic [24:0] lamps_t;

	// vehicle heads as {green, amber, red}
	localparam logic [2:0] veh_g = 3'b100;
	localparam logic [2:0] veh_a = 3'b010;
	localparam logic [2:0] veh_r = 3'b001;
	// southbound head as {green, amber, red, left arrow}
	localparam logic [3:0] sb_g = 4'b1000;
	localparam logic [3:0] sb_a = 4'b0100;
	localparam logic [3:0] sb_r = 4'b0010;
	localparam logic [3:0] sb_l = 4'b0001;
	// pedestrian heads as {walk, flashing dont walk, dont walk}
	localparam logic [2:0] ped_w = 3'b100;
	localparam logic [2:0] ped_f = 3'b010;
	localparam logic [2:0] ped_d = 3'b001;

	// expected lamps per phase, order is north, south, east, west
	localparam lamps_t l_ew_green = {veh_r, ped_d, sb_r, ped_d, veh_g, ped_d, veh_g, ped_d};
	localparam lamps_t l_ew_walk  = {veh_r, ped_d, sb_r, ped_d, veh_g, ped_w, veh_g, ped_w};
	localparam lamps_t l_ew_flash = {veh_r, ped_d, sb_r, ped_d, veh_g, ped_f, veh_g, ped_f};
	localparam lamps_t l_ew_amber = {veh_r, ped_d, sb_r, ped_d, veh_a, ped_d, veh_a, ped_d};
	localparam lamps_t l_all_red  = {veh_r, ped_d, sb_r, ped_d, veh_r, ped_d, veh_r, ped_d};
	// left arrow replaces southbound red, northbound stays red
	localparam lamps_t l_sb_left  = {veh_r, ped_d, sb_l, ped_d, veh_r, ped_d, veh_r, ped_d};
	localparam lamps_t l_ns_green = {veh_g, ped_d, sb_g, ped_d, veh_r, ped_d, veh_r, ped_d};
	localparam lamps_t l_ns_walk  = {veh_g, ped_w, sb_g, ped_w, veh_r, ped_d, veh_r, ped_d};
	localparam lamps_t l_ns_flash = {veh_g, ped_f, sb_g, ped_f, veh_r, ped_d, veh_r, ped_d};
	localparam lamps_t l_ns_amber = {veh_a, ped_d, sb_a, ped_d, veh_r, ped_d, veh_r, ped_d};

	logic clk;
	logic reset;
	logic walk_request;
	logic southbound_left_request;
	logic evm_request;
	logic northbound_green, northbound_amber, northbound_red;
	logic northbound_walk, northbound_flashing_dont_walk, northbound_dont_walk;
	logic southbound_green, southbound_amber, southbound_red, southbound_left;
	logic southbound_walk, southbound_flashing_dont_walk, southbound_dont_walk;
	logic eastbound_green, eastbound_amber, eastbound_red;
	logic eastbound_walk, eastbound_flashing_dont_walk, eastbound_dont_walk;
	logic westbound_green, westbound_amber, westbound_red;
	logic westbound_walk, westbound_flashing_dont_walk, westbound_dont_walk;

	// stimulus table, one entry per expected phase
	string  names[$];
	logic   walk_lvl[$];
	logic   left_lvl[$];
	logic   evm_lvl[$];
	phase_t phases[$];
	lamps_t lamps_exp[$];
	int     durations[$];
	int     holds[$];

	int cycle_count;
	int cycle_limit;

	traffic_controller UUT (.*);

	always #5 clk = ~clk;

	// watchdog over the whole run
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the phase sequence did not finish within %0d cycles",
				cycle_limit);
			abort_run();
		end
	end

	function automatic lamps_t lamp_vector();
		return {northbound_green, northbound_amber, northbound_red,
			northbound_walk, northbound_flashing_dont_walk, northbound_dont_walk,
			southbound_green, southbound_amber, southbound_red, southbound_left,
			southbound_walk, southbound_flashing_dont_walk, southbound_dont_walk,
			eastbound_green, eastbound_amber, eastbound_red,
			eastbound_walk, eastbound_flashing_dont_walk, eastbound_dont_walk,
			westbound_green, westbound_amber, westbound_red,
			westbound_walk, westbound_flashing_dont_walk, westbound_dont_walk};
	endfunction

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_lamps(input string name, input lamps_t expected, input lamps_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s lamps expected %b actual %b", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_cycles(input string name, input timer_t expected, input timer_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s cycles expected %0d actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic compare_phase(input string name, input phase_t expected, input phase_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s phase expected %s actual %s",
				name, expected.name(), actual.name());
			abort_run();
		end
	endtask

	task automatic add_row(input string name, input logic w, input logic l, input logic e,
		input phase_t ph, input lamps_t lmp, input int dur);
		names.push_back(name);
		walk_lvl.push_back(w);
		left_lvl.push_back(l);
		evm_lvl.push_back(e);
		phases.push_back(ph);
		lamps_exp.push_back(lmp);
		durations.push_back(dur);
		holds.push_back(0);
	endtask

	task automatic build_table();
		// idle cycle, no requests
		add_row("idle_ew_green", 1'b0, 1'b0, 1'b0, ph_ew_green, l_ew_green, 60);
		add_row("idle_ew_amber", 1'b0, 1'b0, 1'b0, ph_ew_amber, l_ew_amber, 6);
		add_row("idle_red_a", 1'b0, 1'b0, 1'b0, ph_red_a, l_all_red, 2);
		// walk pressed during north-south green
		add_row("walk_ns_green", 1'b1, 1'b0, 1'b0, ph_ns_green, l_ns_green, 60);
		add_row("walk_ns_amber", 1'b0, 1'b0, 1'b0, ph_ns_amber, l_ns_amber, 6);
		add_row("walk_red_b", 1'b0, 1'b0, 1'b0, ph_red_b, l_all_red, 2);
		add_row("walk_ew_walk", 1'b0, 1'b0, 1'b0, ph_ew_walk, l_ew_walk, 10);
		add_row("walk_ew_flash", 1'b0, 1'b0, 1'b0, ph_ew_flash, l_ew_flash, 20);
		add_row("walk_ew_clear", 1'b0, 1'b0, 1'b0, ph_ew_clear, l_ew_green, 30);
		add_row("walk_ew_amber", 1'b0, 1'b0, 1'b0, ph_ew_amber, l_ew_amber, 6);
		add_row("walk_red_a", 1'b0, 1'b0, 1'b0, ph_red_a, l_all_red, 2);
		// request was served, so no walk phases this time round
		add_row("served_ns_green", 1'b0, 1'b0, 1'b0, ph_ns_green, l_ns_green, 60);
		add_row("served_ns_amber", 1'b0, 1'b0, 1'b0, ph_ns_amber, l_ns_amber, 6);
		add_row("served_red_b", 1'b0, 1'b0, 1'b0, ph_red_b, l_all_red, 2);
		// southbound left detector during east-west green
		add_row("left_ew_green", 1'b0, 1'b1, 1'b0, ph_ew_green, l_ew_green, 60);
		add_row("left_ew_amber", 1'b0, 1'b0, 1'b0, ph_ew_amber, l_ew_amber, 6);
		add_row("left_red_a", 1'b0, 1'b0, 1'b0, ph_red_a, l_all_red, 2);
		add_row("left_sb_left", 1'b0, 1'b0, 1'b0, ph_sb_left, l_sb_left, 20);
		add_row("left_ns_green", 1'b0, 1'b0, 1'b0, ph_ns_green, l_ns_green, 60);
		add_row("left_ns_amber", 1'b0, 1'b0, 1'b0, ph_ns_amber, l_ns_amber, 6);
		add_row("left_red_b", 1'b0, 1'b0, 1'b0, ph_red_b, l_all_red, 2);
		// walk and left both latched, left goes first
		add_row("both_ew_green", 1'b1, 1'b1, 1'b0, ph_ew_green, l_ew_green, 60);
		add_row("both_ew_amber", 1'b0, 1'b0, 1'b0, ph_ew_amber, l_ew_amber, 6);
		add_row("both_red_a", 1'b0, 1'b0, 1'b0, ph_red_a, l_all_red, 2);
		add_row("both_sb_left", 1'b0, 1'b0, 1'b0, ph_sb_left, l_sb_left, 20);
		add_row("both_ns_walk", 1'b0, 1'b0, 1'b0, ph_ns_walk, l_ns_walk, 10);
		add_row("both_ns_flash", 1'b0, 1'b0, 1'b0, ph_ns_flash, l_ns_flash, 20);
		add_row("both_ns_clear", 1'b0, 1'b0, 1'b0, ph_ns_clear, l_ns_green, 30);
		add_row("both_ns_amber", 1'b0, 1'b0, 1'b0, ph_ns_amber, l_ns_amber, 6);
		add_row("both_red_b", 1'b0, 1'b0, 1'b0, ph_red_b, l_all_red, 2);
		// emergency vehicle held past the end of east-west green
		add_row("evm_ew_green", 1'b0, 1'b0, 1'b1, ph_ew_green, l_ew_green, 60);
		add_row("evm_ew_amber", 1'b0, 1'b0, 1'b0, ph_ew_amber, l_ew_amber, 6);
		add_row("evm_red_a", 1'b0, 1'b0, 1'b0, ph_red_a, l_all_red, 2);
	endtask

	// starts on the first falling edge of the phase, ends on the first one of the next
	task automatic run_row(input int i);
		int measured;
		int pulse;
		int evm_start;
		int extra;
		pulse = 0;
		evm_start = 0;
		if (durations[i] > 2) begin
			pulse = $urandom_range(durations[i] - 2, 1);
			evm_start = $urandom_range(durations[i] - 2, 1);
		end
		extra = evm_lvl[i] ? holds[i] : 0;
		compare_phase(names[i], phases[i], UUT.phase);
		check_lamps(names[i], lamps_exp[i], lamp_vector());
		measured = 0;
		// count cycles until the lamps move on
		while (lamp_vector() === lamps_exp[i]) begin
			measured = measured + 1;
			@(posedge clk);
			// index of the cycle that this edge starts
			walk_request <= walk_lvl[i] && (measured == pulse);
			southbound_left_request <= left_lvl[i] && (measured == pulse);
			// evm covers the expiry cycle and then extra cycles
			evm_request <= evm_lvl[i] && (measured >= evm_start) &&
				(measured < durations[i] - 1 + extra);
			@(negedge clk);
		end
		check_cycles(names[i], timer_t'(durations[i]), timer_t'(measured - extra));
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		walk_request = 1'b0;
		southbound_left_request = 1'b0;
		evm_request = 1'b0;
		cycle_count = 0;
		void'($urandom(35716));
		build_table();
		// reset cycles plus margin
		cycle_limit = 52;
		foreach (durations[i]) begin
			if (evm_lvl[i]) begin
				holds[i] = $urandom_range(20, 1);
			end
			cycle_limit = cycle_limit + durations[i] + holds[i];
		end
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// reset phase counts from the releasing edge
		@(negedge clk);
		foreach (names[i]) begin
			run_row(i);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* project.f */
logic/traffic_pkg.sv
logic/request_latch.sv
logic/phase_timer.sv
logic/phase_sequencer.sv
logic/signal_heads.sv
logic/traffic_controller.sv
bench/traffic_controller_tb.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = traffic_controller_tb
FILELIST   = project.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
